// File: list.f
verilog/cpuPkg.sv
verilog/busPkg.sv
verilog/busArbiter.sv
verilog/registerFile.sv
verilog/aluUnit.sv
verilog/controlSequencer.sv
verilog/programMemory.sv
verilog/datapath.sv
tb/clockGen.sv
tb/datapathTb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module datapathTb \
    -f list.f -o datapathSim || { echo "Verilator build failed"; exit 1; }
./obj_dir/datapathSim > sim.log 2>&1
cat sim.log
grep -q 'Test failures found' sim.log && { echo "simulation failed"; exit 1; }
grep -q 'All tests passed!' sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

// File: tb/datapathTb.sv
`timescale 1ns/10ps
module datapathTb;

    typedef struct packed {
        cpuPkg::opcodeT op;
        logic [31:0]    b;
        logic [31:0]    c;
        logic [31:0]    expected;
    } entryT;

    logic                            Clock;
    logic                            rstN;
    logic                            start;
    logic                            loadValid;
    logic [cpuPkg::memAddrWidth-1:0] loadAddr;
    logic [31:0]                     loadData;
    logic                            busy;
    logic                            done;
    logic [31:0]                     outPort;
    logic                            outValid;

    entryT       vectors[$];
    logic [31:0] progWords[5];
    logic [31:0] lcgState;

    clockGen i_clock (
        .Clock (Clock),
        .rstN  (rstN)
    );

    datapath i_dut (
        .Clock     (Clock),
        .rstN      (rstN),
        .start     (start),
        .loadValid (loadValid),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .busy      (busy),
        .done      (done),
        .outPort   (outPort),
        .outValid  (outValid)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            abortRun($sformatf("MISMATCH at %0d ns: %s, got %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // sign-extends the upper 19 bits of the LCG into a legal immediate
    function automatic logic [31:0] randOperand();
        logic [31:0] r;
        r = nextRand();
        return {{13{r[31]}}, r[31:13]};
    endfunction

    function automatic cpuPkg::opcodeT pickOp(input int k);
        case (k % 7)
            0: return cpuPkg::opAdd;
            1: return cpuPkg::opSub;
            2: return cpuPkg::opAnd;
            3: return cpuPkg::opOr;
            4: return cpuPkg::opNot;
            5: return cpuPkg::opNeg;
            default: return cpuPkg::opAddi;
        endcase
    endfunction

    // b comes from rb through Y and c is the bus operand at T4
    function automatic logic [31:0] expectedResult(input cpuPkg::opcodeT op,
                                                   input logic [31:0] b, input logic [31:0] c);
        case (op)
            cpuPkg::opAdd:  return b + c;
            cpuPkg::opAddi: return b + c;
            cpuPkg::opSub:  return b - c;
            cpuPkg::opAnd:  return b & c;
            cpuPkg::opOr:   return b | c;
            cpuPkg::opNot:  return ~c;
            cpuPkg::opNeg:  return 32'd0 - c;
            default:        return 32'd0;
        endcase
    endfunction

    function automatic void addEntry(input cpuPkg::opcodeT op, input logic [31:0] b,
                                     input logic [31:0] c, input logic [31:0] expected);
        entryT e;
        e.op = op;
        e.b = b;
        e.c = c;
        e.expected = expected;
        vectors.push_back(e);
    endfunction

    function automatic void buildVectors();
        logic [31:0] b;
        logic [31:0] c;
        addEntry(cpuPkg::opAdd, 32'd5, 32'd7, 32'd12);
        addEntry(cpuPkg::opAdd, 32'hffff_ffff, 32'd1, 32'd0); // wraps to zero
        addEntry(cpuPkg::opSub, 32'd0, 32'd1, 32'hffff_ffff);
        addEntry(cpuPkg::opSub, 32'd100, 32'd300, 32'hffff_ff38);
        addEntry(cpuPkg::opAnd, 32'h0003_f0f0, 32'h0000_ff0f, 32'h0000_f000);
        addEntry(cpuPkg::opOr, 32'h0001_2340, 32'h0000_0005, 32'h0001_2345);
        addEntry(cpuPkg::opOr, 32'hfffc_0000, 32'd1, 32'hfffc_0001);
        addEntry(cpuPkg::opNot, 32'd0, 32'h0000_1234, 32'hffff_edcb);
        addEntry(cpuPkg::opNeg, 32'd0, 32'hfffc_0000, 32'h0004_0000); // most negative imm
        addEntry(cpuPkg::opNeg, 32'd0, 32'd1, 32'hffff_ffff);
        addEntry(cpuPkg::opAddi, 32'd1000, 32'hffff_fffd, 32'h0000_03e5);
        addEntry(cpuPkg::opAddi, 32'h0003_ffff, 32'h0003_ffff, 32'h0007_fffe);
        addEntry(cpuPkg::opAddi, 32'hfffc_0000, 32'hfffc_0000, 32'hfff8_0000);
        for (int k = 0; k < 14; k++) begin
            b = randOperand();
            c = randOperand();
            addEntry(pickOp(k), b, c, expectedResult(pickOp(k), b, c));
        end
    endfunction

    function automatic logic [31:0] encodeReg(input cpuPkg::opcodeT op, input logic [3:0] ra,
                                              input logic [3:0] rb, input logic [3:0] rc);
        cpuPkg::rFormatT f;
        f.opcode = op;
        f.ra = ra;
        f.rb = rb;
        f.rc = rc;
        f.pad = '0;
        return f;
    endfunction

    function automatic logic [31:0] encodeImm(input cpuPkg::opcodeT op, input logic [3:0] ra,
                                              input logic [3:0] rb, input logic [31:0] value);
        cpuPkg::iFormatT f;
        f.opcode = op;
        f.ra = ra;
        f.rb = rb;
        f.imm = value[18:0];
        return f;
    endfunction

    task automatic loadProgram();
        int a;
        for (a = 0; a < 5; a++) begin
            @(posedge Clock);
            loadValid <= 1'b1;
            loadAddr <= cpuPkg::memAddrWidth'(a);
            loadData <= progWords[a];
        end
        @(posedge Clock);
        loadValid <= 1'b0;
    endtask

    task automatic pulseStart();
        @(posedge Clock);
        start <= 1'b1;
        @(posedge Clock);
        start <= 1'b0;
    endtask

    task automatic waitForReset();
        int cycles;
        cycles = 0;
        while (rstN !== 1'b1) begin
            @(posedge Clock);
            cycles++;
            if (cycles > 20) abortRun("reset was never released");
        end
    endtask

    task automatic waitForOutValid(input int idx, output logic [31:0] value);
        int cycles;
        cycles = 0;
        @(negedge Clock);
        while (outValid !== 1'b1) begin
            if (done === 1'b1) abortRun($sformatf("entry %0d: done came before outValid", idx));
            checkValue({31'b0, busy}, 32'd1, $sformatf("entry %0d busy while running", idx));
            cycles++;
            if (cycles > 200) abortRun($sformatf("entry %0d: outValid never came", idx));
            @(negedge Clock);
        end
        checkValue({31'b0, busy}, 32'd1, $sformatf("entry %0d busy at outValid", idx));
        value = outPort;
    endtask

    task automatic waitForDone(input int idx);
        int cycles;
        cycles = 0;
        @(negedge Clock);
        while (done !== 1'b1) begin
            if (outValid === 1'b1) abortRun($sformatf("entry %0d: second outValid", idx));
            checkValue({31'b0, busy}, 32'd1, $sformatf("entry %0d busy before done", idx));
            cycles++;
            if (cycles > 200) abortRun($sformatf("entry %0d: done never came", idx));
            @(negedge Clock);
        end
        checkValue({31'b0, busy}, 32'd0, $sformatf("entry %0d busy with done", idx));
        @(negedge Clock);
        checkValue({31'b0, done}, 32'd0, $sformatf("entry %0d done one cycle", idx));
        checkValue({31'b0, busy}, 32'd0, $sformatf("entry %0d idle after done", idx));
    endtask

    task automatic runEntry(input int idx);
        entryT       e;
        logic [31:0] captured;
        e = vectors[idx];
        progWords[0] = encodeImm(cpuPkg::opAddi, 4'd1, 4'd0, e.b);
        progWords[1] = encodeImm(cpuPkg::opAddi, 4'd2, 4'd0, e.c);
        if (e.op == cpuPkg::opAddi) begin
            progWords[2] = encodeImm(cpuPkg::opAddi, 4'd3, 4'd1, e.c);
        end else begin
            progWords[2] = encodeReg(e.op, 4'd3, 4'd1, 4'd2);
        end
        progWords[3] = encodeReg(cpuPkg::opOut, 4'd3, 4'd0, 4'd0);
        progWords[4] = encodeReg(cpuPkg::opHalt, 4'd0, 4'd0, 4'd0);
        loadProgram();
        pulseStart();
        if (idx % 4 == 2) pulseStart(); // lands while busy and must be ignored
        waitForOutValid(idx, captured);
        checkValue(captured, e.expected, $sformatf("entry %0d opcode %b", idx, e.op));
        waitForDone(idx);
    endtask

    initial begin
        start = 1'b0;
        loadValid = 1'b0;
        loadAddr = '0;
        loadData = '0;
        lcgState = 32'h413f_f15d;
        buildVectors();
        waitForReset();
        @(negedge Clock);
        checkValue({31'b0, busy}, 32'd0, "busy after reset");
        checkValue({31'b0, done}, 32'd0, "done after reset");
        checkValue({31'b0, outValid}, 32'd0, "outValid after reset");
        checkValue(outPort, 32'd0, "outPort after reset");
        for (int idx = 0; idx < vectors.size(); idx++) begin
            runEntry(idx);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: tb/clockGen.sv
`timescale 1ns/10ps
module clockGen (
    output logic Clock,
    output logic rstN
);

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock; // 8 ns period
    end

    // reset held low for the first two rising edges
    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge Clock);
        rstN <= 1'b1;
    end

endmodule

// File: verilog/datapath.sv
`timescale 1ns/10ps
module datapath (
    input  logic                            Clock,
    input  logic                            rstN,
    input  logic                            start,
    input  logic                            loadValid,
    input  logic [cpuPkg::memAddrWidth-1:0] loadAddr,
    input  logic [cpuPkg::wordWidth-1:0]    loadData,
    output logic                            busy,
    output logic                            done,
    output logic [cpuPkg::wordWidth-1:0]    outPort,
    output logic                            outValid
);

    busPkg::busCtrlT              ctrl;
    logic [cpuPkg::wordWidth-1:0] bus;
    logic [cpuPkg::wordWidth-1:0] regData;
    logic [cpuPkg::wordWidth-1:0] pcValue;
    logic [cpuPkg::wordWidth-1:0] mdrData;
    logic [cpuPkg::wordWidth-1:0] zValue;
    logic [cpuPkg::wordWidth-1:0] immValue;

    busArbiter i_arbiter (
        .ctrl     (ctrl),
        .regData  (regData),
        .pcValue  (pcValue),
        .mdrData  (mdrData),
        .zValue   (zValue),
        .immValue (immValue),
        .bus      (bus)
    );

    registerFile i_regs (
        .Clock   (Clock),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .bus     (bus),
        .regData (regData)
    );

    aluUnit i_alu (
        .Clock  (Clock),
        .rstN   (rstN),
        .ctrl   (ctrl),
        .bus    (bus),
        .zValue (zValue)
    );

    programMemory i_mem (
        .Clock     (Clock),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .bus       (bus),
        .loadValid (loadValid),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .busy      (busy),
        .mdrData   (mdrData)
    );

    controlSequencer i_seq (
        .Clock    (Clock),
        .rstN     (rstN),
        .start    (start),
        .bus      (bus),
        .ctrl     (ctrl),
        .pcValue  (pcValue),
        .immValue (immValue),
        .busy     (busy),
        .done     (done),
        .outPort  (outPort),
        .outValid (outValid)
    );

endmodule

// File: verilog/programMemory.sv
`timescale 1ns/10ps
module programMemory (
    input  logic                            Clock,
    input  logic                            rstN,
    input  busPkg::busCtrlT                 ctrl,
    input  logic [cpuPkg::wordWidth-1:0]    bus,
    input  logic                            loadValid,
    input  logic [cpuPkg::memAddrWidth-1:0] loadAddr,
    input  logic [cpuPkg::wordWidth-1:0]    loadData,
    input  logic                            busy,
    output logic [cpuPkg::wordWidth-1:0]    mdrData
);

    logic [cpuPkg::wordWidth-1:0]    mem [cpuPkg::memDepth];
    logic [cpuPkg::memAddrWidth-1:0] mar;
    logic [cpuPkg::wordWidth-1:0]    mdr;

    // host write port, closed while a program runs
    always_ff @(posedge Clock) begin
        if (loadValid && !busy) begin
            mem[loadAddr] <= loadData;
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (ctrl.marLoad) begin
                mar <= bus[cpuPkg::memAddrWidth-1:0]; // word address, upper bits dropped
            end
            if (ctrl.mdrRead) begin
                mdr <= mem[mar];
            end
        end
    end

    assign mdrData = mdr;

    // the host may only load while the sequencer is idle
    assert property (@(posedge Clock) disable iff (!rstN) loadValid |-> !busy)
    else $error("program load while busy");

endmodule

// File: verilog/controlSequencer.sv
`timescale 1ns/10ps
module controlSequencer (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic                         start,
    input  logic [cpuPkg::wordWidth-1:0] bus,
    output busPkg::busCtrlT              ctrl,
    output logic [cpuPkg::wordWidth-1:0] pcValue,
    output logic [cpuPkg::wordWidth-1:0] immValue,
    output logic                         busy,
    output logic                         done,
    output logic [cpuPkg::wordWidth-1:0] outPort,
    output logic                         outValid
);

    typedef enum logic [2:0] {stIdle, stT0, stT1, stT2, stT3, stT4, stT5} stateT;

    stateT                          state;
    cpuPkg::instrT                  ir;
    cpuPkg::opcodeT                 op;
    logic                           isImm;
    logic                           isOut;
    logic                           isHalt;
    logic [cpuPkg::regSelWidth-1:0] regA;
    logic [cpuPkg::regSelWidth-1:0] regB;

    always_comb begin
        op = ir.r.opcode; // same bit position in both views
        isImm = 1'b0;
        isOut = 1'b0;
        isHalt = 1'b0;
        case (op)
            cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd,
            cpuPkg::opOr, cpuPkg::opNot, cpuPkg::opNeg: ;
            cpuPkg::opAddi: isImm = 1'b1;
            cpuPkg::opOut:  isOut = 1'b1;
            default:        isHalt = 1'b1; // halt and any unknown opcode
        endcase
    end

    assign regA = ir.r.ra; // ra and rb sit at the same bits in both views
    assign regB = ir.r.rb;
    assign immValue = {{(cpuPkg::wordWidth - cpuPkg::immWidth){ir.i.imm[cpuPkg::immWidth-1]}},
                       ir.i.imm};

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = op;
        case (state)
            stT0: begin
                ctrl.source = busPkg::srcPc;
                ctrl.marLoad = 1'b1;
            end
            stT1: ctrl.mdrRead = 1'b1;
            stT2: ctrl.source = busPkg::srcMdr; // IR loads from the bus
            stT3: begin
                if (isOut) begin
                    ctrl.source = busPkg::srcReg;
                    ctrl.regSel = regA;
                end else if (!isHalt) begin
                    ctrl.source = busPkg::srcReg;
                    ctrl.regSel = regB;
                    ctrl.yLoad = 1'b1;
                end
            end
            stT4: begin
                ctrl.zLoad = 1'b1;
                if (isImm) begin
                    ctrl.source = busPkg::srcImm;
                end else begin
                    ctrl.source = busPkg::srcReg;
                    ctrl.regSel = ir.r.rc;
                end
            end
            stT5: begin
                ctrl.source = busPkg::srcZ;
                ctrl.regSel = regA;
                ctrl.regLoad = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
            pcValue <= '0;
            ir <= '0;
            done <= 1'b0;
            outPort <= '0;
            outValid <= 1'b0;
        end else begin
            done <= 1'b0;
            outValid <= 1'b0;
            case (state)
                stIdle: begin
                    if (start) begin
                        pcValue <= '0; // every program runs from address 0
                        state <= stT0;
                    end
                end
                stT0: begin
                    pcValue <= pcValue + cpuPkg::wordWidth'(1);
                    state <= stT1;
                end
                stT1: state <= stT2;
                stT2: begin
                    ir <= cpuPkg::instrT'(bus);
                    state <= stT3;
                end
                stT3: begin
                    if (isHalt) begin
                        done <= 1'b1;
                        state <= stIdle;
                    end else if (isOut) begin
                        outPort <= bus;
                        outValid <= 1'b1;
                        state <= stT0;
                    end else begin
                        state <= stT4;
                    end
                end
                stT4: state <= stT5;
                stT5: state <= stT0;
                default: state <= stIdle;
            endcase
        end
    end

    assign busy = (state != stIdle);

    // the host pulses start for exactly one cycle
    assert property (@(posedge Clock) disable iff (!rstN) start |=> !start)
    else $error("start held for more than one cycle");

endmodule

// File: verilog/aluUnit.sv
`timescale 1ns/10ps
module aluUnit (
    input  logic                         Clock,
    input  logic                         rstN,
    input  busPkg::busCtrlT              ctrl,
    input  logic [cpuPkg::wordWidth-1:0] bus,
    output logic [cpuPkg::wordWidth-1:0] zValue
);

    logic [cpuPkg::wordWidth-1:0] yReg;
    logic [cpuPkg::wordWidth-1:0] zReg;
    logic [cpuPkg::wordWidth-1:0] result;

    // Y is the first operand, the bus carries the second
    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::opAdd,
            cpuPkg::opAddi: result = yReg + bus;
            cpuPkg::opSub:  result = yReg - bus;
            cpuPkg::opAnd:  result = yReg & bus;
            cpuPkg::opOr:   result = yReg | bus;
            cpuPkg::opNot:  result = ~bus; // unary, Y ignored
            cpuPkg::opNeg:  result = -bus;
            default:        result = '0;
        endcase
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            yReg <= '0;
        end else if (ctrl.yLoad) begin
            yReg <= bus;
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            zReg <= '0;
        end else if (ctrl.zLoad) begin
            zReg <= result;
        end
    end

    assign zValue = zReg;

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/10ps
module registerFile (
    input  logic                         Clock,
    input  logic                         rstN,
    input  busPkg::busCtrlT              ctrl,
    input  logic [cpuPkg::wordWidth-1:0] bus,
    output logic [cpuPkg::wordWidth-1:0] regData
);

    logic [cpuPkg::wordWidth-1:0] regs [cpuPkg::regCount];

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < cpuPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regLoad) begin
            regs[ctrl.regSel] <= bus; // write-back from Z
        end
    end

    assign regData = regs[ctrl.regSel];

endmodule

// File: verilog/busArbiter.sv
`timescale 1ns/10ps
module busArbiter (
    input  busPkg::busCtrlT              ctrl,
    input  logic [cpuPkg::wordWidth-1:0] regData,
    input  logic [cpuPkg::wordWidth-1:0] pcValue,
    input  logic [cpuPkg::wordWidth-1:0] mdrData,
    input  logic [cpuPkg::wordWidth-1:0] zValue,
    input  logic [cpuPkg::wordWidth-1:0] immValue,
    output logic [cpuPkg::wordWidth-1:0] bus
);

    always_comb begin
        case (ctrl.source)
            busPkg::srcReg: bus = regData;
            busPkg::srcPc:  bus = pcValue;
            busPkg::srcMdr: bus = mdrData;
            busPkg::srcZ:   bus = zValue;
            busPkg::srcImm: bus = immValue;
            default:        bus = '0; // srcNone and idle cycles
        endcase

        // the sequencer must only ever name a defined source
        assert final (ctrl.source inside {busPkg::srcNone, busPkg::srcReg, busPkg::srcPc,
                                          busPkg::srcMdr, busPkg::srcZ, busPkg::srcImm})
        else $error("illegal bus source %0d", ctrl.source);

        // a register write-back never reads the register file in the same cycle
        assert final (!(ctrl.regLoad && ctrl.source == busPkg::srcReg))
        else $error("register load with register file as bus source");
    end

endmodule

// File: verilog/busPkg.sv
package busPkg;

    // who drives the internal bus this cycle
    typedef enum logic [2:0] {
        srcNone = 3'd0, // bus reads zero
        srcReg  = 3'd1,
        srcPc   = 3'd2,
        srcMdr  = 3'd3,
        srcZ    = 3'd4,
        srcImm  = 3'd5
    } busSourceT;

    // control word from the sequencer, one per cycle
    typedef struct packed {
        busSourceT                      source;
        logic [cpuPkg::regSelWidth-1:0] regSel; // register for bus out and bus load
        logic                           regLoad;
        logic                           marLoad;
        logic                           mdrRead;
        logic                           yLoad;
        logic                           zLoad;
        cpuPkg::opcodeT                 aluOp;
    } busCtrlT;

endpackage

// File: verilog/cpuPkg.sv
package cpuPkg;

    localparam int wordWidth = 32;
    localparam int regCount = 16;
    localparam int memDepth = 64;

    localparam int opcodeWidth = 5;
    localparam int regSelWidth = $clog2(regCount);
    localparam int immWidth = wordWidth - opcodeWidth - 2 * regSelWidth; // 19 bits
    localparam int padWidth = wordWidth - opcodeWidth - 3 * regSelWidth; // 15 bits
    localparam int memAddrWidth = $clog2(memDepth);

    // top five bits of every instruction word
    typedef enum logic [opcodeWidth-1:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opNot  = 5'b10010, // bitwise not of rc
        opNeg  = 5'b10001, // two's complement of rc
        opAddi = 5'b01100,
        opOut  = 5'b10110,
        opHalt = 5'b11011
    } opcodeT;

    // register form: ra <= rb op rc
    typedef struct packed {
        opcodeT                 opcode;
        logic [regSelWidth-1:0] ra; // destination, or source for out
        logic [regSelWidth-1:0] rb;
        logic [regSelWidth-1:0] rc;
        logic [padWidth-1:0]    pad;
    } rFormatT;

    // immediate form: ra <= rb + imm
    typedef struct packed {
        opcodeT                     opcode;
        logic [regSelWidth-1:0]     ra;
        logic [regSelWidth-1:0]     rb;
        logic signed [immWidth-1:0] imm;
    } iFormatT;

    // one IR word, viewed by opcode
    typedef union packed {
        rFormatT r;
        iFormatT i;
    } instrT;

endpackage
